// ==== verilog/lsu_pkg.sv ====
package lsu_pkg;

  typedef logic [31:0] addr_t;
  typedef logic [31:0] word_t;
  typedef logic [3:0]  strb_t;
  typedef logic [2:0]  axi_size_t;
  typedef logic [1:0]  axi_resp_t;

  localparam axi_resp_t RESP_OKAY = 2'b00;

  localparam axi_size_t SIZE_BYTE = 3'd0;
  localparam axi_size_t SIZE_HALF = 3'd1;
  localparam axi_size_t SIZE_WORD = 3'd2;

endpackage

// ==== verilog/lsu_ifs.sv ====
`timescale 1ns/1ps

interface lsu_req_if;
  import lsu_pkg::*;

  logic      start;
  logic      is_load;
  logic      is_store;
  addr_t     addr;
  axi_size_t size;
  strb_t     wstrb;
  word_t     wdata;  // Already in its byte lanes
  logic      sext;
  logic      byte_op;
  logic      half_op;
  logic      misaligned;

  modport producer (
    output start, is_load, is_store, addr, size, wstrb, wdata,
    output sext, byte_op, half_op, misaligned
  );

  modport consumer (
    input start, is_load, is_store, addr, size, wstrb, wdata,
    input sext, byte_op, half_op, misaligned
  );
endinterface

interface axi_lite_if;
  import lsu_pkg::*;

  logic      arvalid;
  addr_t     araddr;
  axi_size_t arsize;
  logic      arready;

  logic      rvalid;
  word_t     rdata;
  axi_resp_t rresp;
  logic      rready;

  logic      awvalid;
  addr_t     awaddr;
  axi_size_t awsize;
  logic      awready;

  logic      wvalid;
  word_t     wdata;
  strb_t     wstrb;
  logic      wready;

  logic      bvalid;
  axi_resp_t bresp;
  logic      bready;

  modport master (
    output arvalid, araddr, arsize, rready,
    output awvalid, awaddr, awsize, wvalid, wdata, wstrb, bready,
    input  arready, rvalid, rdata, rresp, awready, wready, bvalid, bresp
  );

  modport slave (
    input  arvalid, araddr, arsize, rready,
    input  awvalid, awaddr, awsize, wvalid, wdata, wstrb, bready,
    output arready, rvalid, rdata, rresp, awready, wready, bvalid, bresp
  );
endinterface

// ==== verilog/lsu_request_stage.sv ====
`timescale 1ns/1ps

module lsu_request_stage (
  input  logic            clock,
  input  logic            reset,
  input  logic            ex_valid,
  input  logic            ren,
  input  logic            wen,
  input  logic            suffix_b,
  input  logic            suffix_h,
  input  logic            sext,
  input  lsu_pkg::addr_t  addr,
  input  lsu_pkg::word_t  wsrc,
  input  logic            clear_pipeline,
  input  logic            busy,
  lsu_req_if.producer     req
);
  import lsu_pkg::*;

  logic  accept;
  logic  ren_q;
  logic  wen_q;
  logic  byte_q;
  logic  half_q;
  logic  sext_q;
  addr_t addr_q;
  word_t wsrc_q;
  strb_t base_strb;

  assign accept = ex_valid & ~busy;

  always_ff @(posedge clock) begin
    if (reset) begin
      req.start <= 1'b0;
      ren_q     <= 1'b0;
      wen_q     <= 1'b0;
    end else begin
      req.start <= accept & (ren | wen) & ~clear_pipeline;  // Cancelled requests never start
      if (accept) begin
        ren_q <= ren;
        wen_q <= wen;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (accept) begin
      addr_q <= addr;
      byte_q <= suffix_b;
      half_q <= suffix_h;
      sext_q <= sext;
      wsrc_q <= wsrc;
    end
  end

  assign base_strb = byte_q ? 4'b0001 : (half_q ? 4'b0011 : 4'b1111);

  assign req.is_load  = ren_q;
  assign req.is_store = wen_q;
  assign req.addr     = addr_q;
  assign req.size     = byte_q ? SIZE_BYTE : (half_q ? SIZE_HALF : SIZE_WORD);
  assign req.wstrb    = base_strb << addr_q[1:0];
  assign req.wdata    = wsrc_q << {addr_q[1:0], 3'b000};
  assign req.sext     = sext_q;
  assign req.byte_op  = byte_q;
  assign req.half_op  = half_q;

  // Halves may sit at offsets 0 to 2, bytes anywhere
  assign req.misaligned = byte_q ? 1'b0 :
                          half_q ? (addr_q[1:0] == 2'd3) : (addr_q[1:0] != 2'd0);

endmodule

// ==== verilog/lsu_axi_master.sv ====
`timescale 1ns/1ps

module lsu_axi_master (
  input  logic            clock,
  input  logic            reset,
  input  logic            clear_pipeline,
  input  logic            ex_valid,
  input  logic            mem_op,
  lsu_req_if.consumer     req,
  axi_lite_if.master      bus,
  output logic            block,
  output logic            load_addr_misaligned,
  output logic            store_addr_misaligned,
  output logic            load_done,
  output logic            store_done,
  output logic            pass_done,
  output lsu_pkg::word_t  rdata
);

  typedef enum logic [2:0] {
    IDLE,
    READ_ADDR,
    READ_DATA,
    WRITE_REQ,
    WRITE_RESP,
    MISALIGNED
  } state_t;

  state_t state;
  logic   accept;
  logic   aw_free;
  logic   w_free;

  assign accept    = (state == IDLE) & ~block & ex_valid & ~clear_pipeline;
  assign pass_done = accept & ~mem_op;
  assign aw_free   = ~bus.awvalid | bus.awready;  // AW beat done or in progress
  assign w_free    = ~bus.wvalid | bus.wready;

  assign bus.araddr = req.addr;
  assign bus.arsize = req.size;
  assign bus.awaddr = req.addr;
  assign bus.awsize = req.size;
  assign bus.wdata  = req.wdata;
  assign bus.wstrb  = req.wstrb;

  always_ff @(posedge clock) begin
    if (reset) begin
      state                 <= IDLE;
      block                 <= 1'b0;
      load_addr_misaligned  <= 1'b0;
      store_addr_misaligned <= 1'b0;
      load_done             <= 1'b0;
      store_done            <= 1'b0;
      bus.arvalid           <= 1'b0;
      bus.rready            <= 1'b0;
      bus.awvalid           <= 1'b0;
      bus.wvalid            <= 1'b0;
      bus.bready            <= 1'b0;
    end else begin
      load_done  <= 1'b0;
      store_done <= 1'b0;
      case (state)
        IDLE: begin
          if (accept && mem_op) begin
            block <= 1'b1;
          end
          if (load_done || store_done) begin
            block <= 1'b0;  // Falls together with ls_valid
          end
          if (req.start) begin
            if (clear_pipeline) begin
              block <= 1'b0;
            end else if (req.misaligned) begin
              state                 <= MISALIGNED;
              load_addr_misaligned  <= req.is_load;
              store_addr_misaligned <= req.is_store;
            end else if (req.is_load) begin
              state       <= READ_ADDR;
              bus.arvalid <= 1'b1;
            end else begin
              state       <= WRITE_REQ;
              bus.awvalid <= 1'b1;  // AW and W go out together
              bus.wvalid  <= 1'b1;
            end
          end
        end
        READ_ADDR: begin
          if (bus.arready) begin
            bus.arvalid <= 1'b0;
            bus.rready  <= 1'b1;
            state       <= READ_DATA;
          end
        end
        READ_DATA: begin
          if (bus.rvalid) begin
            bus.rready <= 1'b0;
            load_done  <= 1'b1;
            state      <= IDLE;
          end
        end
        WRITE_REQ: begin
          if (bus.awready) begin
            bus.awvalid <= 1'b0;
          end
          if (bus.wready) begin
            bus.wvalid <= 1'b0;
          end
          if (aw_free && w_free) begin
            bus.bready <= 1'b1;
            state      <= WRITE_RESP;
          end
        end
        WRITE_RESP: begin
          if (bus.bvalid) begin
            bus.bready <= 1'b0;
            store_done <= 1'b1;
            state      <= IDLE;
          end
        end
        MISALIGNED: begin
          if (clear_pipeline) begin
            block                 <= 1'b0;
            load_addr_misaligned  <= 1'b0;
            store_addr_misaligned <= 1'b0;
            state                 <= IDLE;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (bus.rvalid && bus.rready) begin
      rdata <= bus.rdata;
    end
  end

endmodule

// ==== verilog/lsu_load_align.sv ====
`timescale 1ns/1ps

module lsu_load_align (
  input  logic            clock,
  input  logic            reset,
  lsu_req_if.consumer     req,
  input  logic            load_done,
  input  logic            store_done,
  input  logic            pass_done,
  input  lsu_pkg::word_t  rdata,
  input  lsu_pkg::word_t  exu_r_wdata,
  output lsu_pkg::word_t  r_wdata,
  output logic            ls_valid
);
  import lsu_pkg::*;

  word_t shifted;
  word_t load_value;
  word_t exu_q;

  assign shifted = rdata >> {req.addr[1:0], 3'b000};

  always_comb begin
    if (req.byte_op) begin
      load_value = {{24{req.sext & shifted[7]}}, shifted[7:0]};
    end else if (req.half_op) begin
      load_value = {{16{req.sext & shifted[15]}}, shifted[15:0]};
    end else begin
      load_value = shifted;
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      ls_valid <= 1'b0;
    end else begin
      ls_valid <= load_done | store_done | pass_done;
    end
  end

  // exu_q still holds the request's value when start arrives
  always_ff @(posedge clock) begin
    exu_q <= exu_r_wdata;
    if (pass_done) begin
      r_wdata <= exu_r_wdata;
    end else if (load_done) begin
      r_wdata <= load_value;
    end else if (req.start) begin
      r_wdata <= exu_q;  // Stores keep this value
    end
  end

endmodule

// ==== verilog/lsu_data_sram.sv ====
`timescale 1ns/1ps

module lsu_data_sram #(
  parameter int MEM_WORDS  = 256,
  parameter int RESP_DELAY = 2
) (
  input  logic       clock,
  input  logic       reset,
  axi_lite_if.slave  bus
);
  import lsu_pkg::*;

  localparam int IDX_W = (MEM_WORDS > 1) ? $clog2(MEM_WORDS) : 1;
  localparam int CNT_W = (RESP_DELAY > 1) ? $clog2(RESP_DELAY) : 1;

  typedef enum logic [1:0] {
    S_IDLE,
    S_DELAY,
    S_RESP
  } state_t;

  state_t           state;
  logic [CNT_W-1:0] cnt;
  logic             is_read;
  logic             rd_go;
  logic             wr_go;
  logic [IDX_W-1:0] rd_idx;
  logic [IDX_W-1:0] wr_idx;
  word_t            rdata_q;
  word_t            mem [MEM_WORDS];

  initial begin
    for (int i = 0; i < MEM_WORDS; i++) begin
      mem[i] = '0;
    end
  end

  assign rd_go  = (state == S_IDLE) & bus.arvalid;
  assign wr_go  = (state == S_IDLE) & bus.awvalid & bus.wvalid & ~bus.arvalid;  // Reads first
  assign rd_idx = IDX_W'((bus.araddr >> 2) % MEM_WORDS);
  assign wr_idx = IDX_W'((bus.awaddr >> 2) % MEM_WORDS);

  assign bus.arready = rd_go;
  assign bus.awready = wr_go;
  assign bus.wready  = wr_go;
  assign bus.rvalid  = (state == S_RESP) & is_read;
  assign bus.bvalid  = (state == S_RESP) & ~is_read;
  assign bus.rdata   = rdata_q;
  assign bus.rresp   = RESP_OKAY;
  assign bus.bresp   = RESP_OKAY;

  always_ff @(posedge clock) begin
    if (reset) begin
      state <= S_IDLE;
      cnt   <= '0;
    end else begin
      case (state)
        S_IDLE: begin
          if (rd_go || wr_go) begin
            if (RESP_DELAY == 0) begin
              state <= S_RESP;
            end else begin
              state <= S_DELAY;
              cnt   <= CNT_W'(RESP_DELAY - 1);
            end
          end
        end
        S_DELAY: begin
          if (cnt == '0) begin
            state <= S_RESP;
          end else begin
            cnt <= cnt - 1'b1;
          end
        end
        S_RESP: begin
          if ((bus.rvalid && bus.rready) || (bus.bvalid && bus.bready)) begin
            state <= S_IDLE;
          end
        end
        default: state <= S_IDLE;
      endcase
    end
  end

  always @(posedge clock) begin
    if (rd_go || wr_go) begin
      is_read <= rd_go;
    end
    if (rd_go) begin
      rdata_q <= mem[rd_idx];
    end
    for (int b = 0; b < 4; b++) begin
      if (wr_go && bus.wstrb[b]) begin
        mem[wr_idx][8*b +: 8] <= bus.wdata[8*b +: 8];  // Only strobed lanes
      end
    end
  end

endmodule

// ==== verilog/lsu_top.sv ====
`timescale 1ns/1ps

module lsu_top #(
  parameter int MEM_WORDS  = 256,
  parameter int RESP_DELAY = 2
) (
  input  logic            clock,
  input  logic            reset,
  input  logic            ex_valid,
  input  logic            ren,
  input  logic            wen,
  input  logic            suffix_b,
  input  logic            suffix_h,
  input  logic            sext,
  input  logic            clear_pipeline,
  input  lsu_pkg::addr_t  addr,
  input  lsu_pkg::word_t  wsrc,
  input  lsu_pkg::word_t  exu_r_wdata,
  output lsu_pkg::word_t  r_wdata,
  output logic            ls_valid,
  output logic            block,
  output logic            load_addr_misaligned,
  output logic            store_addr_misaligned
);
  import lsu_pkg::*;

  logic  load_done;
  logic  store_done;
  logic  pass_done;
  word_t rdata;

  lsu_req_if  req_if ();
  axi_lite_if axi_if ();

  lsu_request_stage i_request (
    .clock          (clock),
    .reset          (reset),
    .ex_valid       (ex_valid),
    .ren            (ren),
    .wen            (wen),
    .suffix_b       (suffix_b),
    .suffix_h       (suffix_h),
    .sext           (sext),
    .addr           (addr),
    .wsrc           (wsrc),
    .clear_pipeline (clear_pipeline),
    .busy           (block),
    .req            (req_if.producer)
  );

  lsu_axi_master i_master (
    .clock                 (clock),
    .reset                 (reset),
    .clear_pipeline        (clear_pipeline),
    .ex_valid              (ex_valid),
    .mem_op                (ren | wen),
    .req                   (req_if.consumer),
    .bus                   (axi_if.master),
    .block                 (block),
    .load_addr_misaligned  (load_addr_misaligned),
    .store_addr_misaligned (store_addr_misaligned),
    .load_done             (load_done),
    .store_done            (store_done),
    .pass_done             (pass_done),
    .rdata                 (rdata)
  );

  lsu_load_align i_align (
    .clock       (clock),
    .reset       (reset),
    .req         (req_if.consumer),
    .load_done   (load_done),
    .store_done  (store_done),
    .pass_done   (pass_done),
    .rdata       (rdata),
    .exu_r_wdata (exu_r_wdata),
    .r_wdata     (r_wdata),
    .ls_valid    (ls_valid)
  );

  lsu_data_sram #(
    .MEM_WORDS  (MEM_WORDS),
    .RESP_DELAY (RESP_DELAY)
  ) i_sram (
    .clock (clock),
    .reset (reset),
    .bus   (axi_if.slave)
  );

endmodule

// ==== tb/lsu_top_checker.sv ====
`timescale 1ns/1ps

module lsu_top_checker (
  input logic clock,
  input logic reset,
  input logic block,
  input logic arvalid,
  input logic arready,
  input logic rvalid,
  input logic rready,
  input logic awvalid,
  input logic awready,
  input logic wvalid,
  input logic wready,
  input logic bvalid,
  input logic bready
);

  ar_held: assert property (@(posedge clock) disable iff (reset) arvalid && !arready |=> arvalid)
    else $error("arvalid dropped before arready");
  r_held: assert property (@(posedge clock) disable iff (reset) rvalid && !rready |=> rvalid)
    else $error("rvalid dropped before rready");
  aw_held: assert property (@(posedge clock) disable iff (reset) awvalid && !awready |=> awvalid)
    else $error("awvalid dropped before awready");
  w_held: assert property (@(posedge clock) disable iff (reset) wvalid && !wready |=> wvalid)
    else $error("wvalid dropped before wready");
  b_held: assert property (@(posedge clock) disable iff (reset) bvalid && !bready |=> bvalid)
    else $error("bvalid dropped before bready");

  // Write address and data leave together
  aw_with_w: assert property (@(posedge clock) disable iff (reset) $rose(awvalid) |-> $rose(wvalid))
    else $error("awvalid rose without wvalid");
  w_with_aw: assert property (@(posedge clock) disable iff (reset) $rose(wvalid) |-> $rose(awvalid))
    else $error("wvalid rose without awvalid");

  no_traffic_unblocked: assert property (@(posedge clock) disable iff (reset)
    !block |-> !(arvalid || rvalid || awvalid || wvalid || bvalid))
    else $error("AXI valid high while block is low");

endmodule

// ==== tb/tb_lsu_top.sv ====
`timescale 1ns/1ps

module tb_lsu_top;
  import lsu_pkg::*;

  localparam int MEM_WORDS  = 256;
  localparam int RESP_DELAY = 2;
  localparam int TIMEOUT    = 40;

  logic  clock;
  logic  reset;
  logic  ex_valid;
  logic  ren;
  logic  wen;
  logic  suffix_b;
  logic  suffix_h;
  logic  sext;
  logic  clear_pipeline;
  addr_t addr;
  word_t wsrc;
  word_t exu_r_wdata;
  word_t r_wdata;
  logic  ls_valid;
  logic  block;
  logic  load_addr_misaligned;
  logic  store_addr_misaligned;

  word_t  model [MEM_WORDS];
  integer seed;
  int     errors;

  lsu_top #(.MEM_WORDS(MEM_WORDS), .RESP_DELAY(RESP_DELAY)) i_dut (.*);

  bind lsu_axi_master lsu_top_checker i_checker (
    .clock   (clock),
    .reset   (reset),
    .block   (block),
    .arvalid (bus.arvalid),
    .arready (bus.arready),
    .rvalid  (bus.rvalid),
    .rready  (bus.rready),
    .awvalid (bus.awvalid),
    .awready (bus.awready),
    .wvalid  (bus.wvalid),
    .wready  (bus.wready),
    .bvalid  (bus.bvalid),
    .bready  (bus.bready)
  );

  initial clock = 1'b0;
  always #50 clock = ~clock;

  task automatic check_word(input string name, input word_t got, input word_t exp);
    assert (got === exp) else begin
      $display("[FAIL] %s: got %h expected %h", name, got, exp);
      errors++;
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    assert (got === exp) else begin
      $display("[FAIL] %s: got %h expected %h", name, got, exp);
      errors++;
    end
  endtask

  function automatic int rand_below(input int n);
    return ($random(seed) & 32'h7fff_ffff) % n;
  endfunction

  function automatic int word_index(input addr_t a);
    return int'((a >> 2) % MEM_WORDS);  // Same wrap as the SRAM
  endfunction

  function automatic logic is_misaligned(input addr_t a, input int size);
    return (size == 2 && a[1:0] != 2'd0) || (size == 1 && a[1:0] == 2'd3);
  endfunction

  function automatic word_t expected_load(input addr_t a, input int size, input logic signed_ld);
    word_t value;
    value = model[word_index(a)] >> (8 * a[1:0]);
    if (size == 0) begin
      value = value & 32'h0000_00ff;
      if (signed_ld && value[7]) value = value | 32'hffff_ff00;
    end else if (size == 1) begin
      value = value & 32'h0000_ffff;
      if (signed_ld && value[15]) value = value | 32'hffff_0000;
    end
    return value;
  endfunction

  task automatic store_model(input addr_t a, input int size, input word_t data);
    int idx;
    int lane;
    idx = word_index(a);
    for (int i = 0; i < (1 << size); i++) begin
      lane = int'(a[1:0]) + i;
      model[idx][8*lane +: 8] = data[8*i +: 8];
    end
  endtask

  // Holds the request for one cycle, returns on the next falling edge
  task automatic drive_request(input logic r, input logic w, input int size, input logic s,
                               input addr_t a, input word_t data, input word_t exu,
                               input logic cancel);
    ex_valid       = 1'b1;
    ren            = r;
    wen            = w;
    suffix_b       = (size == 0);
    suffix_h       = (size == 1);
    sext           = s;
    addr           = a;
    wsrc           = data;
    exu_r_wdata    = exu;
    clear_pipeline = cancel;
    @(negedge clock);
    ex_valid       = 1'b0;
    clear_pipeline = 1'b0;
  endtask

  task automatic expect_quiet();
    repeat (RESP_DELAY + 4) begin
      check_bit("ls_valid", ls_valid, 1'b0);
      check_bit("block", block, 1'b0);
      @(negedge clock);
    end
  endtask

  task automatic run_pass(input word_t exu, input logic cancel);
    drive_request(1'b0, 1'b0, 2, 1'b0, $random(seed), $random(seed), exu, cancel);
    if (cancel) begin
      expect_quiet();
    end else begin
      check_bit("ls_valid", ls_valid, 1'b1);
      check_word("r_wdata", r_wdata, exu);
    end
  endtask

  task automatic clear_misaligned(input logic is_load);
    int cycles;
    cycles = 0;
    while (!(load_addr_misaligned || store_addr_misaligned) && cycles < TIMEOUT) begin
      check_bit("block", block, 1'b1);
      @(negedge clock);
      cycles++;
    end
    assert (load_addr_misaligned || store_addr_misaligned) else begin
      $display("Timed out waiting for a misalignment flag");
      errors++;
    end
    check_bit("load_addr_misaligned", load_addr_misaligned, is_load);
    check_bit("store_addr_misaligned", store_addr_misaligned, !is_load);
    repeat (3) begin
      check_bit("block", block, 1'b1);
      check_bit("ls_valid", ls_valid, 1'b0);
      @(negedge clock);
    end
    clear_pipeline = 1'b1;
    @(negedge clock);
    clear_pipeline = 1'b0;
    check_bit("load_addr_misaligned", load_addr_misaligned, 1'b0);
    check_bit("store_addr_misaligned", store_addr_misaligned, 1'b0);
    check_bit("block", block, 1'b0);
    check_bit("ls_valid", ls_valid, 1'b0);
  endtask

  task automatic run_mem(input logic is_load, input int size, input logic s,
                         input addr_t a, input word_t data, input logic cancel);
    word_t exu;
    word_t exp;
    int    cycles;
    exu = $random(seed);
    exp = is_load ? expected_load(a, size, s) : exu;  // Stores return exu_r_wdata
    drive_request(is_load, !is_load, size, s, a, data, exu, cancel);
    if (cancel) begin
      expect_quiet();
    end else if (is_misaligned(a, size)) begin
      clear_misaligned(is_load);
    end else begin
      cycles = 0;
      while (!ls_valid && cycles < TIMEOUT) begin
        check_bit("block", block, 1'b1);
        @(negedge clock);
        cycles++;
      end
      assert (ls_valid) else begin
        $display("Timed out waiting for ls_valid after access at %h", a);
        errors++;
      end
      check_bit("block", block, 1'b0);
      check_word("r_wdata", r_wdata, exp);
      if (!is_load) store_model(a, size, data);
    end
  endtask

  initial begin
    addr_t a;
    word_t d;
    int    kind;
    int    size;
    logic  cancel;
    seed           = 68;
    errors         = 0;
    reset          = 1'b1;
    ex_valid       = 1'b0;
    ren            = 1'b0;
    wen            = 1'b0;
    suffix_b       = 1'b0;
    suffix_h       = 1'b0;
    sext           = 1'b0;
    clear_pipeline = 1'b0;
    addr           = '0;
    wsrc           = '0;
    exu_r_wdata    = '0;
    for (int i = 0; i < MEM_WORDS; i++) model[i] = '0;
    repeat (5) @(negedge clock);
    reset = 1'b0;

    check_bit("ls_valid", ls_valid, 1'b0);
    check_bit("block", block, 1'b0);
    check_bit("load_addr_misaligned", load_addr_misaligned, 1'b0);
    check_bit("store_addr_misaligned", store_addr_misaligned, 1'b0);
    repeat (8) run_pass($random(seed), 1'b0);

    repeat (20) begin  // Word store then load
      a = addr_t'($random(seed)) & 32'hffff_fffc;
      run_mem(1'b0, 2, 1'b0, a, $random(seed), 1'b0);
      run_mem(1'b1, 2, 1'b0, a, '0, 1'b0);
    end

    repeat (6) begin  // Partial stores, checked by word loads
      a = addr_t'($random(seed)) & 32'hffff_fffc;
      for (int off = 0; off < 4; off++) begin
        run_mem(1'b0, 0, 1'b0, a + addr_t'(off), $random(seed), 1'b0);
        run_mem(1'b1, 2, 1'b0, a, '0, 1'b0);
      end
      for (int off = 0; off < 3; off++) begin
        run_mem(1'b0, 1, 1'b0, a + addr_t'(off), $random(seed), 1'b0);
        run_mem(1'b1, 2, 1'b0, a, '0, 1'b0);
      end
    end

    repeat (4) begin  // Partial loads, both extensions
      a = addr_t'($random(seed)) & 32'hffff_fffc;
      run_mem(1'b0, 2, 1'b0, a, $random(seed), 1'b0);
      for (int s = 0; s < 2; s++) begin
        for (int off = 0; off < 4; off++) run_mem(1'b1, 0, s[0], a + addr_t'(off), '0, 1'b0);
        for (int off = 0; off < 3; off++) run_mem(1'b1, 1, s[0], a + addr_t'(off), '0, 1'b0);
      end
    end

    a = addr_t'($random(seed)) & 32'hffff_fffc;
    run_mem(1'b0, 2, 1'b0, a, $random(seed), 1'b0);
    for (int off = 1; off < 4; off++) begin
      run_mem(1'b1, 2, 1'b0, a + addr_t'(off), '0, 1'b0);
      run_mem(1'b0, 2, 1'b0, a + addr_t'(off), $random(seed), 1'b0);
    end
    run_mem(1'b1, 1, 1'b1, a + 32'd3, '0, 1'b0);
    run_mem(1'b0, 1, 1'b0, a + 32'd3, $random(seed), 1'b0);
    run_mem(1'b1, 2, 1'b0, a, '0, 1'b0);  // Memory untouched

    for (int n = 0; n < 300; n++) begin
      cancel = (rand_below(8) == 0);
      kind   = rand_below(4);
      a      = addr_t'($random(seed)) & 32'hc000_003f;  // Upper bits exercise the wrap
      d      = $random(seed);
      if (kind == 0) begin
        run_pass(d, cancel);
      end else begin
        size = rand_below(3);
        if (rand_below(4) != 0) a = a & ~addr_t'((1 << size) - 1);
        run_mem(kind == 1, size, rand_below(2) == 1, a, d, cancel);
      end
    end

    $display("Errors: %0d", errors);
    if (errors == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

// ==== tb.f ====
verilog/lsu_pkg.sv
verilog/lsu_ifs.sv
verilog/lsu_request_stage.sv
verilog/lsu_axi_master.sv
verilog/lsu_load_align.sv
verilog/lsu_data_sram.sv
verilog/lsu_top.sv
tb/lsu_top_checker.sv
tb/tb_lsu_top.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_lsu_top
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --timing --assert
PASS_MSG  ?= PASS: all tests

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
